// ==== testbench/spi_patterns.txt ====
# op addr data expect, all hex
# W writes a slave register, R reads one into RXDATA, S reads STATUS
S 0 00 00000000
W 3 a5 00000000
R 3 00 000000a5
S 0 00 00000000
R 6 00 00000066
R 0 00 00000000
W 1 3c 00000000
W 2 c3 00000000
R 1 00 0000003c
R 2 00 000000c3
W 3 5a 00000000
R 3 00 0000005a
R 7 00 00000077
S 0 00 00000000

// ==== vlog.f ====
hdl/spi_pkg.sv
hdl/wb_spi_regs.sv
hdl/spi_cmd_engine.sv
hdl/spi_shifter.sv
hdl/spi_wb_top.sv
testbench/spi_slave_model.sv
testbench/tb_spi_wb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_spi_wb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_spi_wb 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// ==== testbench/tb_spi_wb.sv ====
module tb_spi_wb;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 16;
  localparam int CYCLES_PER_OP = 200;

  logic              clk;
  logic              rst_n;
  spi_pkg::wb_req_t  wb_req;
  spi_pkg::wb_rsp_t  wb_rsp;
  logic              sclk;
  logic              cs_n;
  logic              mosi;
  logic              miso;
  spi_pkg::bit_cnt_t frame_bits;
  int                frame_cnt;

  logic [7:0]         pat_op [$];
  logic [2:0]         pat_adr [$];
  spi_pkg::spi_data_t pat_dat [$];
  spi_pkg::wb_data_t  pat_exp [$];
  logic               patterns_loaded = 1'b0;
  int                 frame_base;
  int                 cmd_cnt;

  spi_wb_top uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .sclk   (sclk),
    .cs_n   (cs_n),
    .mosi   (mosi),
    .miso   (miso)
  );

  spi_slave_model slave (
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .frame_bits (frame_bits),
    .frame_cnt  (frame_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(input spi_pkg::spi_data_t got, input spi_pkg::spi_data_t exp,
                            input string what);
    if (got !== exp)
    begin
      $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_word(input spi_pkg::wb_data_t got, input spi_pkg::wb_data_t exp,
                            input string what);
    if (got !== exp)
    begin
      $display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_bits(input spi_pkg::bit_cnt_t got, input spi_pkg::bit_cnt_t exp,
                            input string what);
    if (got !== exp)
    begin
      $display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic load_patterns();
    int                 fd;
    int                 r;
    string              line;
    logic [7:0]         op;
    logic [2:0]         adr;
    spi_pkg::spi_data_t dat;
    spi_pkg::wb_data_t  exp;
    fd = $fopen("testbench/spi_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the pattern file testbench/spi_patterns.txt");
      end_with_failure();
    end
    while ($fgets(line, fd) > 0)
    begin
      if ((line.len() > 0) && (line[0] != "#"))
      begin
        r = $sscanf(line, "%c %h %h %h", op, adr, dat, exp);
        if (r == 4)
        begin
          pat_op.push_back(op);
          pat_adr.push_back(adr);
          pat_dat.push_back(dat);
          pat_exp.push_back(exp);
        end
      end
    end
    $fclose(fd);
    if (pat_op.size() == 0)
    begin
      $display("the pattern file holds no operations");
      end_with_failure();
    end
    patterns_loaded = 1'b1;
  endtask

  // request held from a falling edge until ack is seen
  task automatic wb_write(input spi_pkg::wb_addr_t adr, input spi_pkg::wb_data_t dat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_read(input spi_pkg::wb_addr_t adr, output spi_pkg::wb_data_t dat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    dat        = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  // every earlier frame must be closed when the CMD ack comes back
  task automatic send_cmd(input logic write, input logic [2:0] adr,
                          input spi_pkg::spi_data_t dat);
    spi_pkg::spi_cmd_t cmd;
    cmd = {write, adr, dat};
    wb_write(spi_pkg::REG_CMD, spi_pkg::wb_data_t'(cmd));
    check_word(spi_pkg::wb_data_t'(frame_cnt - frame_base), spi_pkg::wb_data_t'(cmd_cnt),
               "frames closed at CMD ack");
    cmd_cnt++;
  endtask

  task automatic wait_idle(output spi_pkg::wb_data_t status);
    wb_read(spi_pkg::REG_STATUS, status);
    while (status[0]) wb_read(spi_pkg::REG_STATUS, status);
  endtask

  initial
  begin
    spi_pkg::wb_data_t rdata;
    rst_n  = 1'b0;
    wb_req = '0;
    load_patterns();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n      = 1'b1;
    frame_base = frame_cnt;
    cmd_cnt    = 0;
    // cs_n high and sclk low
    check_word(spi_pkg::wb_data_t'({cs_n, sclk}), 32'h2, "cs_n and sclk after reset");
    for (int i = 0; i < pat_op.size(); i++)
    begin
      case (pat_op[i])
        "W":
        begin
          send_cmd(1'b1, pat_adr[i], pat_dat[i]);
        end
        "R":
        begin
          send_cmd(1'b0, pat_adr[i], '0);
          wait_idle(rdata);
          check_word(rdata, 32'h2, "STATUS after read");
          wb_read(spi_pkg::REG_RXDATA, rdata);
          check_byte(rdata[7:0], pat_exp[i][7:0], "RXDATA");
        end
        "S":
        begin
          wb_read(spi_pkg::REG_STATUS, rdata);
          check_word(rdata, pat_exp[i], "STATUS");
        end
        default:
        begin
          $display("unknown operation on pattern line %0d", i);
          end_with_failure();
        end
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  initial
  begin
    wait (rst_n);
    forever
    begin
      @(posedge cs_n);
      @(negedge clk);
      check_bits(frame_bits, spi_pkg::bit_cnt_t'(spi_pkg::CMD_WIDTH), "bits in SPI frame");
    end
  end

  initial
  begin
    wait (patterns_loaded);
    #(pat_op.size() * CYCLES_PER_OP * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
    $display("timeout: transfer never completed");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== testbench/spi_slave_model.sv ====
module spi_slave_model (
  input  logic              sclk,
  input  logic              cs_n,
  input  logic              mosi,
  output logic              miso,
  output spi_pkg::bit_cnt_t frame_bits,
  output int                frame_cnt
);

  spi_pkg::spi_data_t regs [8];
  spi_pkg::spi_cmd_t  rx_frame;
  spi_pkg::bit_cnt_t  bit_cnt;
  spi_pkg::spi_data_t tx_byte;

  // untouched registers hold address times 0x11
  initial
  begin
    for (int i = 0; i < 8; i++)
    begin
      regs[i] = spi_pkg::spi_data_t'(i * 8'h11);
    end
    rx_frame   = '0;
    bit_cnt    = '0;
    tx_byte    = '0;
    miso       = 1'b0;
    frame_bits = '0;
    frame_cnt  = 0;
  end

  // bits are counted on rising sclk, the frame closes when cs_n goes high
  always @(posedge sclk or posedge cs_n)
  begin
    if (cs_n)
    begin
      frame_bits = bit_cnt;
      frame_cnt  = frame_cnt + 1;
      if ((bit_cnt == spi_pkg::bit_cnt_t'(spi_pkg::CMD_WIDTH)) && rx_frame[11])
      begin
        regs[rx_frame[10:8]] = rx_frame[7:0];
      end
      bit_cnt = '0;
    end
    else
    begin
      rx_frame = {rx_frame[10:0], mosi};
      bit_cnt  = bit_cnt + 1'b1;
    end
  end

  // a read turns around after flag and address, miso moves on falling sclk
  always @(negedge sclk)
  begin
    if (!cs_n)
    begin
      if ((bit_cnt == 4'd4) && !rx_frame[3])
      begin
        tx_byte = regs[rx_frame[2:0]];
      end
      else
      begin
        tx_byte = tx_byte << 1;
      end
      miso = tx_byte[7];
    end
  end

endmodule

// ==== hdl/spi_wb_top.sv ====
module spi_wb_top (
  input  logic             clk,
  input  logic             rst_n,
  input  spi_pkg::wb_req_t wb_req,
  output spi_pkg::wb_rsp_t wb_rsp,
  output logic             sclk,
  output logic             cs_n,
  output logic             mosi,
  input  logic             miso
);

  logic               cmd_req;
  spi_pkg::spi_cmd_t  cmd;
  logic               cmd_ack;
  logic               busy;
  logic               rx_strobe;
  spi_pkg::spi_data_t rx_byte;
  logic               job_start;
  spi_pkg::spi_job_t  job;
  logic               done;
  spi_pkg::spi_data_t rx_shift;

  wb_spi_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .busy      (busy),
    .rx_strobe (rx_strobe),
    .rx_byte   (rx_byte)
  );

  spi_cmd_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .busy      (busy),
    .job_start (job_start),
    .job       (job),
    .done      (done),
    .rx_shift  (rx_shift),
    .rx_strobe (rx_strobe),
    .rx_byte   (rx_byte)
  );

  spi_shifter u_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .job_start (job_start),
    .job       (job),
    .done      (done),
    .rx_shift  (rx_shift),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

endmodule

// ==== hdl/spi_shifter.sv ====
module spi_shifter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               job_start,
  input  spi_pkg::spi_job_t  job,
  output logic               done,
  output spi_pkg::spi_data_t rx_shift,
  output logic               sclk,
  output logic               cs_n,
  output logic               mosi,
  input  logic               miso
);

  spi_pkg::shf_state_t state;
  spi_pkg::div_cnt_t   half_cnt;
  spi_pkg::bit_cnt_t   bit_cnt;
  spi_pkg::bit_cnt_t   bit_nxt;
  spi_pkg::bit_cnt_t   n_out_q;
  spi_pkg::bit_cnt_t   n_last;
  spi_pkg::spi_cmd_t   shreg;
  spi_pkg::spi_data_t  rx_q;
  logic                half_end;
  logic                period_end;
  logic                last_bit;
  logic                load;

  assign half_end   = (half_cnt == spi_pkg::HALF_END);
  assign period_end = (half_cnt == spi_pkg::PERIOD_END);
  assign bit_nxt    = bit_cnt + 1'b1;
  assign last_bit   = (bit_cnt == n_last);
  assign load       = (state == spi_pkg::S_IDLE) && job_start;
  assign rx_shift   = rx_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= spi_pkg::S_IDLE;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk     <= 1'b0;
      cs_n     <= 1'b1;
      mosi     <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        spi_pkg::S_IDLE:
        begin
          half_cnt <= '0;
          bit_cnt  <= '0;
          if (job_start)
          begin
            // first bit is on mosi before the first rising edge
            cs_n  <= 1'b0;
            mosi  <= job.frame[spi_pkg::CMD_WIDTH-1];
            state <= spi_pkg::S_SETUP;
          end
        end
        spi_pkg::S_SETUP:
        begin
          half_cnt <= half_cnt + 1'b1;
          if (half_end)
          begin
            half_cnt <= '0;
            sclk     <= 1'b1;
            state    <= spi_pkg::S_CLOCK;
          end
        end
        spi_pkg::S_CLOCK:
        begin
          half_cnt <= half_cnt + 1'b1;
          // falling edge, next out bit or zero once the out bits run dry
          if (half_end)
          begin
            sclk <= 1'b0;
            mosi <= (bit_nxt < n_out_q) ? shreg[spi_pkg::CMD_WIDTH-2] : 1'b0;
          end
          if (period_end)
          begin
            half_cnt <= '0;
            if (last_bit)
            begin
              state <= spi_pkg::S_HOLD;
            end
            else
            begin
              bit_cnt <= bit_nxt;
              sclk    <= 1'b1;
            end
          end
        end
        spi_pkg::S_HOLD:
        begin
          half_cnt <= half_cnt + 1'b1;
          if (half_end)
          begin
            half_cnt <= '0;
            cs_n     <= 1'b1;
            done     <= 1'b1;
            state    <= spi_pkg::S_IDLE;
          end
        end
        default:
        begin
          state <= spi_pkg::S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shreg   <= job.frame;
      n_out_q <= job.n_out;
      n_last  <= job.n_out + job.n_in - 1'b1;
    end
    else if (state == spi_pkg::S_CLOCK)
    begin
      // miso is taken in the first clock of the high phase
      if ((half_cnt == '0) && (bit_cnt >= n_out_q))
      begin
        rx_q <= {rx_q[spi_pkg::READ_WIDTH-2:0], miso};
      end
      if (half_end)
      begin
        shreg <= shreg << 1;
      end
    end
  end

endmodule

// ==== hdl/spi_cmd_engine.sv ====
module spi_cmd_engine (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_req,
  input  spi_pkg::spi_cmd_t  cmd,
  output logic               cmd_ack,
  output logic               busy,
  output logic               job_start,
  output spi_pkg::spi_job_t  job,
  input  logic               done,
  input  spi_pkg::spi_data_t rx_shift,
  output logic               rx_strobe,
  output spi_pkg::spi_data_t rx_byte
);

  spi_pkg::eng_state_t state;
  spi_pkg::spi_cmd_t   cmd_q;
  spi_pkg::spi_cmd_t   rd_frame;
  logic                is_write;
  logic                accept;

  assign is_write = cmd_q[spi_pkg::CMD_WIDTH-1];
  assign accept   = (state == spi_pkg::IDLE) && cmd_req;

  // busy covers DECODE through POST
  assign busy = (state != spi_pkg::IDLE);

  // read frame keeps only the flag and the address, data bits go out as zero
  assign rd_frame = {cmd_q[spi_pkg::CMD_WIDTH-1 -: spi_pkg::RD_OUT_BITS],
                     {(spi_pkg::CMD_WIDTH - spi_pkg::RD_OUT_BITS){1'b0}}};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= spi_pkg::IDLE;
      cmd_ack   <= 1'b0;
      job_start <= 1'b0;
      rx_strobe <= 1'b0;
    end
    else
    begin
      cmd_ack   <= 1'b0;
      job_start <= 1'b0;
      rx_strobe <= 1'b0;
      case (state)
        spi_pkg::IDLE:
        begin
          if (cmd_req)
          begin
            cmd_ack <= 1'b1;
            state   <= spi_pkg::DECODE;
          end
        end
        spi_pkg::DECODE:
        begin
          job_start <= 1'b1;
          state     <= spi_pkg::SHIFT;
        end
        spi_pkg::SHIFT:
        begin
          if (done)
          begin
            // only reads post a byte back to the registers
            rx_strobe <= !is_write;
            state     <= spi_pkg::POST;
          end
        end
        spi_pkg::POST:
        begin
          state <= spi_pkg::IDLE;
        end
        default:
        begin
          state <= spi_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd;
    end
  end

  // job is built in DECODE and stays stable for the whole transfer
  always_ff @(posedge clk)
  begin
    if (state == spi_pkg::DECODE)
    begin
      if (is_write)
      begin
        job.frame <= cmd_q;
        job.n_out <= spi_pkg::bit_cnt_t'(spi_pkg::CMD_WIDTH);
        job.n_in  <= '0;
      end
      else
      begin
        job.frame <= rd_frame;
        job.n_out <= spi_pkg::bit_cnt_t'(spi_pkg::RD_OUT_BITS);
        job.n_in  <= spi_pkg::bit_cnt_t'(spi_pkg::READ_WIDTH);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == spi_pkg::SHIFT) && done)
    begin
      rx_byte <= rx_shift;
    end
  end

endmodule

// ==== hdl/wb_spi_regs.sv ====
module wb_spi_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::wb_req_t   wb_req,
  output spi_pkg::wb_rsp_t   wb_rsp,
  output logic               cmd_req,
  output spi_pkg::spi_cmd_t  cmd,
  input  logic               cmd_ack,
  input  logic               busy,
  input  logic               rx_strobe,
  input  spi_pkg::spi_data_t rx_byte
);

  logic               ack_q;
  spi_pkg::wb_data_t  dat_q;
  logic               rx_valid;
  spi_pkg::spi_data_t rx_data;
  logic               bus_hit;
  logic               cmd_wr;
  logic               plain_ack;
  logic               bus_rd;
  logic               rd_rx;

  // a new cycle is seen only while no ack is on the bus
  assign bus_hit = wb_req.cyc && wb_req.stb && !ack_q;

  // CMD writes wait for the engine, so the bus stalls while a transfer runs
  assign cmd_wr = bus_hit && wb_req.we && (wb_req.adr == spi_pkg::REG_CMD);

  // every other access is answered one clock after stb
  assign plain_ack = bus_hit && !cmd_wr;
  assign bus_rd    = plain_ack && !wb_req.we;
  assign rd_rx     = bus_rd && (wb_req.adr == spi_pkg::REG_RXDATA);

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q   <= 1'b0;
      cmd_req <= 1'b0;
    end
    else
    begin
      ack_q <= plain_ack || (cmd_req && cmd_ack);
      if (cmd_ack)
      begin
        cmd_req <= 1'b0;
      end
      else if (cmd_wr)
      begin
        cmd_req <= 1'b1;
      end
    end
  end

  // command word is captured once, when the request goes up
  always_ff @(posedge clk)
  begin
    if (cmd_wr && !cmd_req)
    begin
      cmd <= wb_req.dat[spi_pkg::CMD_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_valid <= 1'b0;
    end
    else if (rx_strobe)
    begin
      // a fresh byte wins over a read in the same cycle
      rx_valid <= 1'b1;
    end
    else if (rd_rx)
    begin
      rx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_strobe)
    begin
      rx_data <= rx_byte;
    end
  end

  // read mux, unmapped offsets return zero
  always_ff @(posedge clk)
  begin
    if (bus_rd)
    begin
      case (wb_req.adr)
        spi_pkg::REG_STATUS:
        begin
          dat_q <= spi_pkg::wb_data_t'({rx_valid, busy});
        end
        spi_pkg::REG_RXDATA:
        begin
          dat_q <= spi_pkg::wb_data_t'(rx_data);
        end
        default:
        begin
          dat_q <= '0;
        end
      endcase
    end
  end

endmodule

// ==== hdl/spi_pkg.sv ====
package spi_pkg;

  // frame layout: write flag, register address, write data
  localparam int CMD_WIDTH   = 12;
  localparam int READ_WIDTH  = 8;
  localparam int ADDR_WIDTH  = 3;
  // a read sends the flag and the address before turning around
  localparam int RD_OUT_BITS = 1 + ADDR_WIDTH;

  // system clocks per sclk half period
  localparam int SCLK_HALF   = 4;
  localparam int DIV_W       = $clog2(2 * SCLK_HALF);

  localparam int WB_AW = 4;
  localparam int WB_DW = 32;

  typedef logic [CMD_WIDTH-1:0]  spi_cmd_t;
  typedef logic [READ_WIDTH-1:0] spi_data_t;
  typedef logic [WB_AW-1:0]      wb_addr_t;
  typedef logic [WB_DW-1:0]      wb_data_t;
  typedef logic [3:0]            bit_cnt_t;
  typedef logic [DIV_W-1:0]      div_cnt_t;

  // byte offsets of the register map
  localparam wb_addr_t REG_CMD    = 4'h0;
  localparam wb_addr_t REG_STATUS = 4'h4;
  localparam wb_addr_t REG_RXDATA = 4'h8;

  // last count of a half period and of a full sclk period
  localparam div_cnt_t HALF_END   = div_cnt_t'(SCLK_HALF - 1);
  localparam div_cnt_t PERIOD_END = div_cnt_t'(2 * SCLK_HALF - 1);

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  // frame is left aligned, MSB goes out first
  typedef struct packed {
    spi_cmd_t frame;
    bit_cnt_t n_out;
    bit_cnt_t n_in;
  } spi_job_t;

  typedef enum logic [1:0] {
    IDLE,
    DECODE,
    SHIFT,
    POST
  } eng_state_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_SETUP,
    S_CLOCK,
    S_HOLD
  } shf_state_t;

endpackage
